// File: src.f
+incdir+src
src/stepper_pkg.sv
src/axil_regs.sv
src/move_fsm.sv
src/step_timer.sv
src/phase_sequencer.sv
src/current_pwm.sv
src/stepper_top.sv
sim/tb_stepper.sv

// File: run_sim.sh
#!/bin/sh
# Build tb_stepper with Verilator, run it, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  -f src.f --top-module tb_stepper -o tb_stepper > build.log 2>&1 &&
./obj_dir/tb_stepper > sim.log 2>&1 ||
{ echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || { echo "No result line in sim.log"; exit 1; }
exit 0

// File: sim/tb_stepper.sv
`timescale 1ns/1ps
`default_nettype none
`include "stepper_params.svh"

module tb_stepper;

  localparam int TMO = 64;  // Cycles per handshake wait

  logic                    step;
  logic                    arst_n;
  logic [`STP_ADDR_W-1:0]  s_awaddr;
  logic                    s_awvalid;
  logic                    s_awready;
  logic [`STP_DATA_W-1:0]  s_wdata;
  logic                    s_wvalid;
  logic                    s_wready;
  logic [1:0]              s_bresp;
  logic                    s_bvalid;
  logic                    s_bready;
  logic [`STP_ADDR_W-1:0]  s_araddr;
  logic                    s_arvalid;
  logic                    s_arready;
  logic [`STP_DATA_W-1:0]  s_rdata;
  logic [1:0]              s_rresp;
  logic                    s_rvalid;
  logic                    s_rready;
  logic                    phase_a1;
  logic                    phase_a2;
  logic                    phase_b1;
  logic                    phase_b2;
  logic                    vref_a;
  logic                    vref_b;
  logic [3:0]              coil_out;     // {b2, b1, a2, a1}
  logic [3:0]              last_coil;
  logic [3:0]              coil_table [8];
  logic [`STP_ADDR_W-1:0]  holes [4];    // Unmapped offsets
  logic [3:0]              chg_pat [$];  // Coil patterns seen by the monitor
  int                      chg_cyc [$];  // Cycle of each change
  logic [2:0]              model_idx;
  logic                    mon_on;
  int                      cycle;
  int                      errors;
  int                      seed;

  stepper_top stepper_top_i (
    .step(step), .arst_n(arst_n),
    .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
    .s_wdata(s_wdata), .s_wvalid(s_wvalid), .s_wready(s_wready),
    .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
    .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
    .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2),
    .vref_a(vref_a), .vref_b(vref_b)
  );

  assign coil_out = {phase_b2, phase_b1, phase_a2, phase_a1};

  always #10 step = ~step;  // 20 ns period
  always @(posedge step) cycle <= cycle + 1;

  // Coil monitor sampled mid-cycle
  always @(negedge step) begin
    if (mon_on && coil_out != last_coil) begin
      chg_pat.push_back(coil_out);
      chg_cyc.push_back(cycle);
    end
    last_coil <= coil_out;
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s, got 0x%0h expected 0x%0h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout: the DUT never completed the %s", what);
    errors++;
  endtask

  task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int   n;
    logic aw_hit;
    logic w_hit;
    logic aw_ok;
    logic w_ok;
    logic got;
    resp  = 2'bxx;
    aw_ok = 1'b0;
    w_ok  = 1'b0;
    got   = 1'b0;
    n     = 0;
    @(posedge step);
    s_awaddr  <= addr;
    s_awvalid <= 1'b1;
    s_wdata   <= data;
    s_wvalid  <= 1'b1;
    while (!(aw_ok && w_ok) && n < TMO) begin
      @(negedge step);
      aw_hit = s_awvalid & s_awready;  // Beat taken on the coming edge
      w_hit  = s_wvalid & s_wready;
      @(posedge step);
      if (aw_hit) begin
        s_awvalid <= 1'b0;
        aw_ok = 1'b1;
      end
      if (w_hit) begin
        s_wvalid <= 1'b0;
        w_ok = 1'b1;
      end
      n++;
    end
    if (!(aw_ok && w_ok)) begin
      note_timeout("write address and data handshake");
      s_awvalid <= 1'b0;
      s_wvalid  <= 1'b0;
    end
    s_bready <= 1'b1;
    n = 0;
    while (!got && n < TMO) begin
      @(negedge step);
      if (s_bvalid) begin
        got  = 1'b1;
        resp = s_bresp;
      end
      n++;
    end
    @(posedge step);
    s_bready <= 1'b0;
    if (!got) note_timeout("write response");
  endtask

  task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int   n;
    logic hit;
    logic got;
    data = 'x;
    resp = 2'bxx;
    hit  = 1'b0;
    got  = 1'b0;
    n    = 0;
    @(posedge step);
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    while (!hit && n < TMO) begin
      @(negedge step);
      hit = s_arvalid & s_arready;
      n++;
    end
    @(posedge step);
    s_arvalid <= 1'b0;
    s_rready  <= 1'b1;
    if (!hit) note_timeout("read address handshake");
    n = 0;
    while (!got && n < TMO) begin
      @(negedge step);
      if (s_rvalid) begin
        got  = 1'b1;
        data = s_rdata;
        resp = s_rresp;
      end
      n++;
    end
    @(posedge step);
    s_rready <= 1'b0;
    if (!got) note_timeout("read data");
  endtask

  // Poll STATUS until busy clears
  task automatic wait_idle(output logic [31:0] st);
    int         n;
    logic [1:0] r;
    n  = 0;
    st = 32'h1;
    while (st[0] && n < 400) begin
      axil_read(`STP_REG_STATUS, st, r);
      n++;
    end
    if (st[0]) note_timeout("move, busy stayed high");
  endtask

  // One random move with its coil trace checked against the table model
  task automatic run_move();
    logic [31:0] rnd;
    logic [31:0] st;
    logic [1:0]  r;
    logic        dir;
    logic [1:0]  us;
    logic [2:0]  inc;
    int          per;
    int          cnt;
    rnd = $random(seed);
    dir = rnd[0];
    us  = rnd[3:2];
    per = 1 + int'(rnd[15:8]) % 20;
    cnt = 1 + int'(rnd[23:16]) % 24;
    inc = (us == 2'd0) ? 3'd4 : (us == 2'd1) ? 3'd2 : 3'd1;  // Code 3 acts as quarter
    axil_write(`STP_REG_CTRL, {28'd0, us, dir, 1'b1}, r);
    axil_write(`STP_REG_PERIOD, per, r);
    repeat (4) @(posedge step);  // Let the enable pattern settle
    chg_pat.delete();
    chg_cyc.delete();
    mon_on = 1'b1;
    axil_write(`STP_REG_COUNT, cnt, r);
    check_eq(r, `STP_RESP_OKAY, "COUNT write response");
    wait_idle(st);
    repeat (2) @(posedge step);
    mon_on = 1'b0;
    axil_read(`STP_REG_STATUS, st, r);  // Settled STATUS after the last coil change
    check_eq(chg_pat.size(), cnt, "number of coil changes");
    for (int i = 0; i < cnt; i++) begin
      model_idx = dir ? model_idx + inc : model_idx - inc;
      if (i < chg_pat.size()) check_eq(chg_pat[i], coil_table[model_idx], "coil pattern");
    end
    for (int i = 1; i < chg_cyc.size(); i++)
      check_eq(chg_cyc[i] - chg_cyc[i-1], per, "cycles between coil changes");
    check_eq(st[0], 1'b0, "STATUS busy after move");
    check_eq(st[1], 1'b1, "STATUS done after move");
    check_eq(st[31:16], 16'd0, "STATUS remaining after move");
    check_eq(st[4:2], model_idx, "STATUS phase index");
  endtask

  initial begin
    logic [31:0] d;
    logic [31:0] rd;
    logic [1:0]  r;
    int          hi_a;
    int          hi_b;
    coil_table = '{4'b1010, 4'b0010, 4'b0110, 4'b0100, 4'b0101, 4'b0001, 4'b1001, 4'b1000};
    holes      = '{5'h14, 5'h18, 5'h1C, 5'h06};
    seed       = 32'hbc4c;
    errors     = 0;
    cycle      = 0;
    mon_on     = 1'b0;
    model_idx  = 3'd0;
    step       = 1'b0;
    arst_n     = 1'b0;
    s_awaddr   = '0;
    s_awvalid  = 1'b0;
    s_wdata    = '0;
    s_wvalid   = 1'b0;
    s_bready   = 1'b0;
    s_araddr   = '0;
    s_arvalid  = 1'b0;
    s_rready   = 1'b0;
    repeat (16) @(posedge step);
    arst_n <= 1'b1;
    repeat (2) @(posedge step);

    // Reset state
    @(negedge step);
    check_eq(coil_out, 4'd0, "phases after reset");
    check_eq({vref_a, vref_b}, 2'd0, "vref after reset");
    axil_read(`STP_REG_STATUS, rd, r);
    check_eq(rd, 32'd0, "STATUS after reset");

    // Register readback
    repeat (8) begin
      d = $random(seed);
      axil_write(`STP_REG_CTRL, d, r);
      check_eq(r, `STP_RESP_OKAY, "CTRL write response");
      axil_read(`STP_REG_CTRL, rd, r);
      check_eq(rd, d & 32'hF, "CTRL readback");
      d = $random(seed);
      axil_write(`STP_REG_PERIOD, d, r);
      axil_read(`STP_REG_PERIOD, rd, r);
      check_eq(rd, d & 32'hFFFF, "PERIOD readback");
      d = $random(seed);
      axil_write(`STP_REG_CURRENT, d, r);
      axil_read(`STP_REG_CURRENT, rd, r);
      check_eq(rd, d & 32'hFF, "CURRENT readback");
      check_eq(r, `STP_RESP_OKAY, "CURRENT read response");
    end
    foreach (holes[k]) begin
      axil_write(holes[k], 32'hdead_beef, r);
      check_eq(r, `STP_RESP_SLVERR, "write to unmapped offset");
      axil_read(holes[k], rd, r);
      check_eq(r, `STP_RESP_SLVERR, "read from unmapped offset");
    end

    // PWM duty over a 256-cycle window
    repeat (4) begin
      d = $random(seed);
      axil_write(`STP_REG_CURRENT, d, r);
      repeat (3) @(negedge step);
      hi_a = 0;
      hi_b = 0;
      repeat (256) begin
        @(negedge step);
        hi_a += vref_a;
        hi_b += vref_b;
      end
      check_eq(hi_a, d[7:0], "vref_a high cycles");
      check_eq(hi_b, d[7:0], "vref_b high cycles");
    end

    // Random moves
    repeat (6) run_move();

    // Enable low ignores a start
    axil_write(`STP_REG_CTRL, 32'd0, r);
    axil_write(`STP_REG_COUNT, 32'd5, r);
    check_eq(r, `STP_RESP_OKAY, "COUNT write while disabled");
    repeat (4) @(posedge step);
    axil_read(`STP_REG_STATUS, rd, r);
    check_eq(rd[0], 1'b0, "busy with enable low");
    @(negedge step);
    check_eq(coil_out, 4'd0, "phases with enable low");

    // Abort mid-move
    axil_write(`STP_REG_PERIOD, 32'd8, r);
    axil_write(`STP_REG_CTRL, 32'd1, r);
    axil_write(`STP_REG_COUNT, 32'd20, r);
    axil_read(`STP_REG_STATUS, rd, r);
    check_eq(rd[0], 1'b1, "busy during move");
    repeat (30) @(posedge step);
    axil_write(`STP_REG_CTRL, 32'd0, r);
    repeat (2) @(negedge step);
    check_eq(coil_out, 4'd0, "phases after abort");
    axil_read(`STP_REG_STATUS, rd, r);
    check_eq(rd[0], 1'b0, "busy after abort");
    check_eq(rd[1], 1'b0, "done after abort");

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/stepper_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "stepper_params.svh"

module stepper_top import stepper_pkg::*; (
  input  wire                     step,
  input  wire                     arst_n,
  input  wire [`STP_ADDR_W-1:0]   s_awaddr,
  input  wire                     s_awvalid,
  output logic                    s_awready,
  input  wire [`STP_DATA_W-1:0]   s_wdata,
  input  wire                     s_wvalid,
  output logic                    s_wready,
  output logic [1:0]              s_bresp,
  output logic                    s_bvalid,
  input  wire                     s_bready,
  input  wire [`STP_ADDR_W-1:0]   s_araddr,
  input  wire                     s_arvalid,
  output logic                    s_arready,
  output logic [`STP_DATA_W-1:0]  s_rdata,
  output logic [1:0]              s_rresp,
  output logic                    s_rvalid,
  input  wire                     s_rready,
  // Dual H-bridge inputs and current references
  output logic                    phase_a1,
  output logic                    phase_a2,
  output logic                    phase_b1,
  output logic                    phase_b2,
  output logic                    vref_a,
  output logic                    vref_b
);

  logic                     enable;
  logic                     dir;
  ustep_t                   ustep;
  logic [`STP_PERIOD_W-1:0] period;
  logic [`STP_DUTY_W-1:0]   duty;
  logic                     move_start;
  logic [`STP_COUNT_W-1:0]  move_count;
  logic                     busy;
  logic                     done;
  logic [`STP_COUNT_W-1:0]  remaining;
  logic [2:0]               phase_idx;
  logic                     run;
  logic                     step_tick;
  logic                     step_adv;
  coil_t                    coil;  // Bridge pattern gathered from the sequencer

  axil_regs axil_regs_i (
    .step(step), .arst_n(arst_n),
    .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
    .s_wdata(s_wdata), .s_wvalid(s_wvalid), .s_wready(s_wready),
    .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
    .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
    .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
    .busy(busy), .done(done), .remaining(remaining), .phase_idx(phase_idx),
    .enable(enable), .dir(dir), .ustep(ustep), .period(period), .duty(duty),
    .move_start(move_start), .move_count(move_count)
  );

  move_fsm move_fsm_i (
    .step(step), .arst_n(arst_n),
    .move_start(move_start), .move_count(move_count),
    .enable(enable), .step_tick(step_tick),
    .run(run), .step_adv(step_adv),
    .busy(busy), .done(done), .remaining(remaining)
  );

  step_timer step_timer_i (
    .step(step), .arst_n(arst_n),
    .run(run), .period(period), .step_tick(step_tick)
  );

  phase_sequencer phase_sequencer_i (
    .step(step), .arst_n(arst_n),
    .step_adv(step_adv), .dir(dir), .ustep(ustep), .enable(enable),
    .phase_a1(coil.a1), .phase_a2(coil.a2),
    .phase_b1(coil.b1), .phase_b2(coil.b2),
    .phase_idx(phase_idx)
  );

  // Both references share one duty, counters run apart
  current_pwm pwm_a (.step(step), .arst_n(arst_n), .duty(duty), .pwm(vref_a));
  current_pwm pwm_b (.step(step), .arst_n(arst_n), .duty(duty), .pwm(vref_b));

  assign phase_a1 = coil.a1;
  assign phase_a2 = coil.a2;
  assign phase_b1 = coil.b1;
  assign phase_b2 = coil.b2;

endmodule

`default_nettype wire

// File: src/current_pwm.sv
`timescale 1ns/1ps
`default_nettype none
`include "stepper_params.svh"

module current_pwm (
  input  wire                    step,
  input  wire                    arst_n,
  input  wire [`STP_DUTY_W-1:0]  duty,  // High cycles per 256
  output logic                   pwm
);

  logic [`STP_DUTY_W-1:0] cnt;  // Free-running, wraps every 256

  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
      pwm <= 1'b0;
    end else begin
      cnt <= cnt + 1'b1;
      pwm <= (cnt < duty);  // Exactly duty highs per wrap
    end
  end

endmodule

`default_nettype wire

// File: src/phase_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer import stepper_pkg::*; (
  input  wire        step,
  input  wire        arst_n,
  input  wire        step_adv,  // One pulse per step
  input  wire        dir,       // 1 walks up the table
  input  ustep_t     ustep,
  input  wire        enable,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2,
  output logic [2:0] phase_idx
);

  logic [2:0] inc;
  logic [2:0] idx_next;
  coil_t      coil_next;
  coil_t      coil_q;

  // Fixed eight-entry coil pattern table
  function automatic coil_t coil_lookup(input logic [2:0] idx);
    case (idx)
      3'd0:    coil_lookup = 4'b1010;
      3'd1:    coil_lookup = 4'b0010;
      3'd2:    coil_lookup = 4'b0110;
      3'd3:    coil_lookup = 4'b0100;
      3'd4:    coil_lookup = 4'b0101;
      3'd5:    coil_lookup = 4'b0001;
      3'd6:    coil_lookup = 4'b1001;
      default: coil_lookup = 4'b1000;
    endcase
  endfunction

  always_comb begin
    case (ustep)
      FULL:    inc = 3'd4;
      HALF:    inc = 3'd2;
      default: inc = 3'd1;  // Quarter and the spare code
    endcase
  end

  // Index wraps mod 8 by width
  assign idx_next  = !step_adv ? phase_idx :
                     dir       ? phase_idx + inc : phase_idx - inc;
  assign coil_next = coil_lookup(idx_next);  // Pattern for the new index, no extra cycle

  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      phase_idx <= '0;
      coil_q    <= '0;
    end else begin
      phase_idx <= idx_next;
      coil_q    <= enable ? coil_next : '0;  // Bridge off when disabled
    end
  end

  assign phase_a1 = coil_q.a1;
  assign phase_a2 = coil_q.a2;
  assign phase_b1 = coil_q.b1;
  assign phase_b2 = coil_q.b2;

endmodule

`default_nettype wire

// File: src/step_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "stepper_params.svh"

module step_timer (
  input  wire                      step,
  input  wire                      arst_n,
  input  wire                      run,        // Level, high during a move
  input  wire [`STP_PERIOD_W-1:0]  period,
  output logic                     step_tick
);

  logic [`STP_PERIOD_W-1:0] cnt;
  logic [`STP_PERIOD_W-1:0] lim_q;    // Terminal count in use
  logic [`STP_PERIOD_W-1:0] lim_new;  // max(period,1)-1

  assign lim_new = (period == '0) ? '0 : period - 1'b1;

  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      cnt       <= '0;
      lim_q     <= '0;
      step_tick <= 1'b0;
    end else if (!run) begin
      // Held at zero so a new move starts clean
      cnt       <= '0;
      lim_q     <= lim_new;
      step_tick <= 1'b0;
    end else if (cnt == lim_q) begin
      cnt       <= '0;
      lim_q     <= lim_new;  // New period lands on the wrap
      step_tick <= 1'b1;
    end else begin
      cnt       <= cnt + 1'b1;
      step_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/move_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "stepper_params.svh"

module move_fsm import stepper_pkg::*; (
  input  wire                     step,
  input  wire                     arst_n,
  input  wire                     move_start,  // Strobe from COUNT write
  input  wire [`STP_COUNT_W-1:0]  move_count,
  input  wire                     enable,
  input  wire                     step_tick,   // Strobe from the timer
  output logic                    run,
  output logic                    step_adv,
  output logic                    busy,
  output logic                    done,
  output logic [`STP_COUNT_W-1:0] remaining
);

  move_state_t state;
  logic        last_step;  // Final tick of the move

  assign run      = (state == RUN);
  assign busy     = run;
  assign step_adv = run & enable & step_tick;  // Same cycle as the tick
  assign last_step = step_adv & (remaining == `STP_COUNT_W'(1));

  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      remaining <= '0;
      done      <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // Start only when enabled, busy rules it out here already
          if (move_start && enable) begin
            state     <= RUN;
            remaining <= move_count;
            done      <= 1'b0;
          end
        end
        RUN: begin
          if (!enable) begin
            state <= IDLE;  // Abort, done stays low
          end else if (step_adv) begin
            remaining <= remaining - 1'b1;
            if (last_step) begin
              state <= IDLE;
              done  <= 1'b1;  // Same edge busy falls
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/axil_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "stepper_params.svh"

module axil_regs import stepper_pkg::*; (
  input  wire                     step,
  input  wire                     arst_n,
  // Write address and data
  input  wire [`STP_ADDR_W-1:0]   s_awaddr,
  input  wire                     s_awvalid,
  output logic                    s_awready,
  input  wire [`STP_DATA_W-1:0]   s_wdata,
  input  wire                     s_wvalid,
  output logic                    s_wready,
  // Write response
  output logic [1:0]              s_bresp,
  output logic                    s_bvalid,
  input  wire                     s_bready,
  // Read address and data
  input  wire [`STP_ADDR_W-1:0]   s_araddr,
  input  wire                     s_arvalid,
  output logic                    s_arready,
  output logic [`STP_DATA_W-1:0]  s_rdata,
  output logic [1:0]              s_rresp,
  output logic                    s_rvalid,
  input  wire                     s_rready,
  // Status from the core
  input  wire                     busy,
  input  wire                     done,
  input  wire [`STP_COUNT_W-1:0]  remaining,
  input  wire [2:0]               phase_idx,
  // Control to the core
  output logic                    enable,
  output logic                    dir,
  output ustep_t                  ustep,
  output logic [`STP_PERIOD_W-1:0] period,
  output logic [`STP_DUTY_W-1:0]  duty,
  output logic                    move_start,
  output logic [`STP_COUNT_W-1:0] move_count
);

  logic                    aw_held;   // Address beat taken, waiting for data
  logic                    w_held;    // Data beat taken, waiting for address
  logic [`STP_ADDR_W-1:0]  awaddr_q;
  logic [`STP_DATA_W-1:0]  wdata_q;
  logic                    aw_hs;
  logic                    w_hs;
  logic                    ar_hs;
  logic                    do_write;  // Both beats present this cycle
  logic [`STP_ADDR_W-1:0]  wr_addr;
  logic [`STP_DATA_W-1:0]  wr_data;
  logic [`STP_DATA_W-1:0]  status_word;
  logic [`STP_DATA_W-1:0]  rd_word;

  function automatic logic addr_mapped(input logic [`STP_ADDR_W-1:0] a);
    case (a)
      `STP_REG_CTRL, `STP_REG_PERIOD, `STP_REG_COUNT,
      `STP_REG_STATUS, `STP_REG_CURRENT: addr_mapped = 1'b1;
      default:                           addr_mapped = 1'b0;
    endcase
  endfunction

  assign aw_hs    = s_awvalid & s_awready;
  assign w_hs     = s_wvalid & s_wready;
  assign ar_hs    = s_arvalid & s_arready;
  assign do_write = (aw_held | aw_hs) & (w_held | w_hs);
  assign wr_addr  = aw_hs ? s_awaddr : awaddr_q;  // Bypass a beat arriving now
  assign wr_data  = w_hs ? s_wdata : wdata_q;

  // busy, done, phase index low, steps remaining in the top half
  assign status_word = {remaining, {(`STP_DATA_W - `STP_COUNT_W - 5){1'b0}},
                        phase_idx, done, busy};

  // Beat payloads
  always_ff @(posedge step) begin
    if (aw_hs) awaddr_q <= s_awaddr;
    if (w_hs)  wdata_q  <= s_wdata;
  end

  // Write handshake, ready pulses one cycle per beat
  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      s_awready <= 1'b0;
      s_wready  <= 1'b0;
      aw_held   <= 1'b0;
      w_held    <= 1'b0;
      s_bvalid  <= 1'b0;
      s_bresp   <= `STP_RESP_OKAY;
    end else begin
      s_awready <= s_awvalid & ~s_awready & ~aw_held & ~s_bvalid;
      s_wready  <= s_wvalid & ~s_wready & ~w_held & ~s_bvalid;
      if (do_write) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
      end else begin
        if (aw_hs) aw_held <= 1'b1;
        if (w_hs)  w_held  <= 1'b1;
      end
      if (do_write) begin
        s_bvalid <= 1'b1;
        s_bresp  <= addr_mapped(wr_addr) ? `STP_RESP_OKAY : `STP_RESP_SLVERR;
      end else if (s_bready) begin
        s_bvalid <= 1'b0;  // Response taken
      end
    end
  end

  // Control registers
  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      enable     <= 1'b0;
      dir        <= 1'b0;
      ustep      <= FULL;
      period     <= '0;
      duty       <= '0;
      move_count <= '0;
      move_start <= 1'b0;
    end else begin
      move_start <= 1'b0;  // Single-cycle strobe
      if (do_write) begin
        case (wr_addr)
          `STP_REG_CTRL: begin
            enable <= wr_data[0];
            dir    <= wr_data[1];
            ustep  <= ustep_t'(wr_data[3:2]);
          end
          `STP_REG_PERIOD:  period <= wr_data[`STP_PERIOD_W-1:0];
          `STP_REG_COUNT: begin
            move_count <= wr_data[`STP_COUNT_W-1:0];
            move_start <= |wr_data[`STP_COUNT_W-1:0];  // Zero count starts nothing
          end
          `STP_REG_CURRENT: duty <= wr_data[`STP_DUTY_W-1:0];
          default: ;  // STATUS and holes ignore writes
        endcase
      end
    end
  end

  // Read mux
  always_comb begin
    case (s_araddr)
      `STP_REG_CTRL:    rd_word = {{(`STP_DATA_W - 4){1'b0}}, ustep, dir, enable};
      `STP_REG_PERIOD:  rd_word = `STP_DATA_W'(period);
      `STP_REG_COUNT:   rd_word = `STP_DATA_W'(move_count);
      `STP_REG_STATUS:  rd_word = status_word;
      `STP_REG_CURRENT: rd_word = `STP_DATA_W'(duty);
      default:          rd_word = '0;
    endcase
  end

  // Read channel, arready tracks an empty data slot
  always_ff @(posedge step or negedge arst_n) begin
    if (!arst_n) begin
      s_arready <= 1'b0;
      s_rvalid  <= 1'b0;
      s_rdata   <= '0;
      s_rresp   <= `STP_RESP_OKAY;
    end else if (ar_hs) begin
      s_arready <= 1'b0;
      s_rvalid  <= 1'b1;
      s_rdata   <= rd_word;
      s_rresp   <= addr_mapped(s_araddr) ? `STP_RESP_OKAY : `STP_RESP_SLVERR;
    end else if (s_rvalid & s_rready) begin
      s_rvalid  <= 1'b0;
      s_arready <= 1'b1;  // Slot frees this edge
    end else begin
      s_arready <= ~s_rvalid;
    end
  end

endmodule

`default_nettype wire

// File: src/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  // Move controller states
  typedef enum logic {
    IDLE = 1'b0,  // Waiting for a start
    RUN  = 1'b1   // Stepping down the count
  } move_state_t;

  // One pattern on the dual H-bridge inputs, a1 in bit 0
  typedef struct packed {
    logic b2;
    logic b1;
    logic a2;
    logic a1;
  } coil_t;

  // Microstep mode, phase increment 4, 2 or 1
  // Code 3 behaves like QUARTER_TABLE
  typedef enum logic [1:0] {
    FULL          = 2'd0,
    HALF          = 2'd1,
    QUARTER_TABLE = 2'd2
  } ustep_t;

endpackage

`default_nettype wire

// File: src/stepper_params.svh
`ifndef STEPPER_PARAMS_SVH
`define STEPPER_PARAMS_SVH

// AXI4-Lite bus widths
`define STP_ADDR_W   5
`define STP_DATA_W   32

// Datapath widths
`define STP_PERIOD_W 16   // Cycles per step
`define STP_COUNT_W  16   // Steps per move
`define STP_DUTY_W   8    // Coil current PWM duty

// Register map, byte offsets
`define STP_REG_CTRL    5'h00  // enable, dir, microstep mode
`define STP_REG_PERIOD  5'h04
`define STP_REG_COUNT   5'h08  // Write starts a move
`define STP_REG_STATUS  5'h0C  // Read only
`define STP_REG_CURRENT 5'h10

// Response codes
`define STP_RESP_OKAY   2'b00
`define STP_RESP_SLVERR 2'b10

`endif
